// File: hw/axi_pkg.sv
package axi_pkg;

    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int LEN_W  = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // shared by AW and AR
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        burst_e            burst;
    } addr_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } wdata_beat_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } bresp_beat_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } rdata_beat_t;

endpackage

// File: hw/slave_pkg.sv
package slave_pkg;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } slave_op_e;

    typedef enum logic [1:0] {
        DEC_IDLE  = 2'd0,
        DEC_WRITE = 2'd1,
        DEC_READ  = 2'd2
    } decode_state_e;

    localparam int MEM_WORDS_DEF = 256; // 1 KiB of 32-bit words

endpackage

// File: hw/slave_req_if.sv
`timescale 1ns/1ps

interface slave_req_if import axi_pkg::*, slave_pkg::*; ();

    logic              valid;
    logic              ready;
    slave_op_e         op;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-3:0] word_index; // byte address over four
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic              last;
    logic              err;
    logic [DATA_W-1:0] rdata;

    modport source (output valid, op, id, word_index, wdata, strb, last, err, rdata,
                    input ready);
    modport sink (input valid, op, id, word_index, wdata, strb, last, err, rdata,
                  output ready);

endinterface

// File: hw/async_fifo.sv
`timescale 1ns/1ps

module async_fifo #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_LOG2 = 2
) (
    input  logic             wr_clk,
    input  logic             wr_rst,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             wr_full,
    input  logic             rd_clk,
    input  logic             rd_rst,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [DEPTH_LOG2:0] wbin, wgray, rbin, rgray;
    logic [DEPTH_LOG2:0] rgray_w1, rgray_w2; // read pointer seen from the write clock
    logic [DEPTH_LOG2:0] wgray_r1, wgray_r2; // write pointer seen from the read clock
    logic [DEPTH_LOG2:0] wbin_next, rbin_next;

    assign wbin_next = wbin + 1'b1;
    assign rbin_next = rbin + 1'b1;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (wr_en) begin
            wbin  <= wbin_next;
            wgray <= (wbin_next >> 1) ^ wbin_next;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_en) begin
            mem[wbin[DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    // full when the gray pointers differ only in the two top bits
    assign wr_full = (wgray == (rgray_w2 ^ {2'b11, {(DEPTH_LOG2-1){1'b0}}}));

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (rd_en) begin
                rbin  <= rbin_next;
                rgray <= (rbin_next >> 1) ^ rbin_next;
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_en) begin
            rd_data <= mem[rbin[DEPTH_LOG2-1:0]];
        end
    end

    assign rd_empty = (rgray == wgray_r2);

    a_no_overflow: assert property (@(posedge wr_clk) disable iff (wr_rst) !(wr_en && wr_full));
    a_no_underflow: assert property (@(posedge rd_clk) disable iff (rd_rst) !(rd_en && rd_empty));

endmodule

// File: hw/slave_axi_async.sv
`timescale 1ns/1ps

module slave_axi_async import axi_pkg::*; #(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic              bus_clk,
    input  logic              bus_rstn,
    input  logic              SLAVE_CLK,
    input  logic              SLAVE_RSTN,
    input  logic [ID_W-1:0]   bus_wr_addr_id,
    input  logic [ADDR_W-1:0] bus_wr_addr,
    input  logic [LEN_W-1:0]  bus_wr_addr_len,
    input  logic [1:0]        bus_wr_addr_burst,
    input  logic              bus_wr_addr_valid,
    output logic              bus_wr_addr_ready,
    input  logic [DATA_W-1:0] bus_wr_data,
    input  logic [STRB_W-1:0] bus_wr_strb,
    input  logic              bus_wr_data_last,
    input  logic              bus_wr_data_valid,
    output logic              bus_wr_data_ready,
    output logic [ID_W-1:0]   bus_wr_back_id,
    output logic [1:0]        bus_wr_back_resp,
    output logic              bus_wr_back_valid,
    input  logic              bus_wr_back_ready,
    input  logic [ID_W-1:0]   bus_rd_addr_id,
    input  logic [ADDR_W-1:0] bus_rd_addr,
    input  logic [LEN_W-1:0]  bus_rd_addr_len,
    input  logic [1:0]        bus_rd_addr_burst,
    input  logic              bus_rd_addr_valid,
    output logic              bus_rd_addr_ready,
    output logic [ID_W-1:0]   bus_rd_back_id,
    output logic [DATA_W-1:0] bus_rd_data,
    output logic [1:0]        bus_rd_data_resp,
    output logic              bus_rd_data_last,
    output logic              bus_rd_data_valid,
    input  logic              bus_rd_data_ready,
    output addr_beat_t        aw_beat,
    output logic              aw_valid,
    input  logic              aw_ready,
    output addr_beat_t        ar_beat,
    output logic              ar_valid,
    input  logic              ar_ready,
    output wdata_beat_t       w_beat,
    output logic              w_valid,
    input  logic              w_ready,
    input  bresp_beat_t       b_beat,
    input  logic              b_valid,
    output logic              b_ready,
    input  rdata_beat_t       r_beat,
    input  logic              r_valid,
    output logic              r_ready
);

    logic        rstn_all;
    logic [4:0]  full, wen;                    // aw, ar, w, b, r
    logic [2:0]  s_empty, s_take, s_pop, s_pf; // receivers on SLAVE_CLK: aw, ar, w
    logic [1:0]  m_empty, m_take, m_pop, m_pf; // receivers on bus_clk: b, r
    bresp_beat_t b_out;
    rdata_beat_t r_out;

    assign rstn_all = bus_rstn && SLAVE_RSTN;

    assign bus_wr_addr_ready = rstn_all && !full[0];
    assign bus_rd_addr_ready = rstn_all && !full[1];
    assign bus_wr_data_ready = rstn_all && !full[2];
    assign b_ready           = rstn_all && !full[3];
    assign r_ready           = rstn_all && !full[4];

    assign wen[0] = bus_wr_addr_valid && bus_wr_addr_ready;
    assign wen[1] = bus_rd_addr_valid && bus_rd_addr_ready;
    assign wen[2] = bus_wr_data_valid && bus_wr_data_ready;
    assign wen[3] = b_valid && b_ready;
    assign wen[4] = r_valid && r_ready;

    // a prefetch flag means the output stage holds nothing worth showing
    assign s_take = {w_valid && w_ready, ar_valid && ar_ready, aw_valid && aw_ready};
    assign s_pop  = ~s_empty & (s_pf | s_take);
    assign m_take = {bus_rd_data_valid && bus_rd_data_ready, bus_wr_back_valid && bus_wr_back_ready};
    assign m_pop  = ~m_empty & (m_pf | m_take);

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            s_pf <= '1;
        end else begin
            s_pf <= (s_pf & ~s_pop) | (s_empty & s_take); // set and clear never meet
        end
    end

    always_ff @(posedge bus_clk) begin
        if (!bus_rstn) begin
            m_pf <= '1;
        end else begin
            m_pf <= (m_pf & ~m_pop) | (m_empty & m_take);
        end
    end

    assign aw_valid          = !s_pf[0];
    assign ar_valid          = !s_pf[1];
    assign w_valid           = !s_pf[2];
    assign bus_wr_back_valid = !m_pf[0];
    assign bus_rd_data_valid = !m_pf[1];

    assign {bus_wr_back_id, bus_wr_back_resp} = b_out;
    assign {bus_rd_back_id, bus_rd_data, bus_rd_data_resp, bus_rd_data_last} = r_out;

    async_fifo #(.WIDTH($bits(addr_beat_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_aw_fifo (
        .wr_clk(bus_clk), .wr_rst(!bus_rstn), .wr_en(wen[0]), .wr_full(full[0]),
        .wr_data({bus_wr_addr_id, bus_wr_addr, bus_wr_addr_len, bus_wr_addr_burst}),
        .rd_clk(SLAVE_CLK), .rd_rst(!SLAVE_RSTN), .rd_en(s_pop[0]), .rd_data(aw_beat),
        .rd_empty(s_empty[0])
    );

    async_fifo #(.WIDTH($bits(addr_beat_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_ar_fifo (
        .wr_clk(bus_clk), .wr_rst(!bus_rstn), .wr_en(wen[1]), .wr_full(full[1]),
        .wr_data({bus_rd_addr_id, bus_rd_addr, bus_rd_addr_len, bus_rd_addr_burst}),
        .rd_clk(SLAVE_CLK), .rd_rst(!SLAVE_RSTN), .rd_en(s_pop[1]), .rd_data(ar_beat),
        .rd_empty(s_empty[1])
    );

    async_fifo #(.WIDTH($bits(wdata_beat_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_w_fifo (
        .wr_clk(bus_clk), .wr_rst(!bus_rstn), .wr_en(wen[2]), .wr_full(full[2]),
        .wr_data({bus_wr_data, bus_wr_strb, bus_wr_data_last}),
        .rd_clk(SLAVE_CLK), .rd_rst(!SLAVE_RSTN), .rd_en(s_pop[2]), .rd_data(w_beat),
        .rd_empty(s_empty[2])
    );

    // response channels run the other way, slave to bus
    async_fifo #(.WIDTH($bits(bresp_beat_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_b_fifo (
        .wr_clk(SLAVE_CLK), .wr_rst(!SLAVE_RSTN), .wr_en(wen[3]), .wr_full(full[3]),
        .wr_data(b_beat),
        .rd_clk(bus_clk), .rd_rst(!bus_rstn), .rd_en(m_pop[0]), .rd_data(b_out),
        .rd_empty(m_empty[0])
    );

    async_fifo #(.WIDTH($bits(rdata_beat_t)), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_r_fifo (
        .wr_clk(SLAVE_CLK), .wr_rst(!SLAVE_RSTN), .wr_en(wen[4]), .wr_full(full[4]),
        .wr_data(r_beat),
        .rd_clk(bus_clk), .rd_rst(!bus_rstn), .rd_en(m_pop[1]), .rd_data(r_out),
        .rd_empty(m_empty[1])
    );

endmodule

// File: hw/slave_decode.sv
`timescale 1ns/1ps

module slave_decode import axi_pkg::*, slave_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic        SLAVE_CLK,
    input  logic        SLAVE_RSTN,
    input  addr_beat_t  aw_beat,
    input  logic        aw_valid,
    output logic        aw_ready,
    input  addr_beat_t  ar_beat,
    input  logic        ar_valid,
    output logic        ar_ready,
    input  wdata_beat_t w_beat,
    input  logic        w_valid,
    output logic        w_ready,
    slave_req_if.source req
);

    localparam int IDX_W = ADDR_W - 2;

    decode_state_e    state;
    addr_beat_t       sel;
    logic [ID_W-1:0]  cur_id;
    logic [IDX_W-1:0] cur_idx;
    logic [LEN_W-1:0] cur_len, beat_cnt;
    burst_e           cur_burst;
    logic             beat_fire;

    assign aw_ready  = (state == DEC_IDLE);
    assign ar_ready  = (state == DEC_IDLE) && !aw_valid; // writes win a tie
    assign w_ready   = (state == DEC_WRITE) && req.ready;
    assign beat_fire = req.valid && req.ready;
    assign sel       = aw_valid ? aw_beat : ar_beat;

    assign req.valid      = (state == DEC_READ) || ((state == DEC_WRITE) && w_valid);
    assign req.op         = (state == DEC_READ) ? OP_READ : OP_WRITE;
    assign req.id         = cur_id;
    assign req.word_index = cur_idx;
    assign req.wdata      = w_beat.data;
    assign req.strb       = w_beat.strb;
    assign req.last       = (beat_cnt == cur_len);
    assign req.err        = (cur_idx >= IDX_W'(MEM_WORDS));
    assign req.rdata      = '0;

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            state <= DEC_IDLE;
        end else begin
            unique case (state)
                DEC_IDLE: begin
                    if (aw_valid) begin
                        state <= DEC_WRITE;
                    end else if (ar_valid) begin
                        state <= DEC_READ;
                    end
                end
                default: begin
                    if (beat_fire && req.last) begin
                        state <= DEC_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if ((state == DEC_IDLE) && (aw_valid || ar_valid)) begin
            cur_id    <= sel.id;
            cur_idx   <= sel.addr[ADDR_W-1:2];
            cur_len   <= sel.len;
            cur_burst <= sel.burst;
            beat_cnt  <= '0;
        end else if (beat_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (cur_burst != FIXED) begin
                cur_idx <= cur_idx + 1'b1; // WRAP steps like INCR
            end
        end
    end

endmodule

// File: hw/slave_execute.sv
`timescale 1ns/1ps

module slave_execute import axi_pkg::*, slave_pkg::*; #(
    parameter int MEM_WORDS = MEM_WORDS_DEF
) (
    input  logic        SLAVE_CLK,
    input  logic        SLAVE_RSTN,
    slave_req_if.sink   req_in,
    slave_req_if.source req_out
);

    localparam int MEM_AW = $clog2(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [MEM_AW-1:0] addr;
    logic              in_fire;
    logic              wr_en;

    assign addr          = req_in.word_index[MEM_AW-1:0];
    assign req_in.ready  = !req_out.valid || req_out.ready;
    assign in_fire       = req_in.valid && req_in.ready;
    assign wr_en         = in_fire && (req_in.op == OP_WRITE) && !req_in.err;

    always_ff @(posedge SLAVE_CLK) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_in.strb[b]) begin
                    mem[addr][8*b +: 8] <= req_in.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            req_out.valid <= 1'b0;
        end else if (in_fire) begin
            req_out.valid <= 1'b1;
        end else if (req_out.ready) begin
            req_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (in_fire) begin
            req_out.op         <= req_in.op;
            req_out.id         <= req_in.id;
            req_out.word_index <= req_in.word_index;
            req_out.wdata      <= req_in.wdata;
            req_out.strb       <= req_in.strb;
            req_out.last       <= req_in.last;
            req_out.err        <= req_in.err;
            // an out-of-range read returns zero
            req_out.rdata      <= (req_in.op == OP_READ && !req_in.err) ? mem[addr] : '0;
        end
    end

endmodule

// File: hw/slave_result.sv
`timescale 1ns/1ps

module slave_result import axi_pkg::*, slave_pkg::*; (
    input  logic        SLAVE_CLK,
    input  logic        SLAVE_RSTN,
    slave_req_if.sink   req,
    output bresp_beat_t b_beat,
    output logic        b_valid,
    input  logic        b_ready,
    output rdata_beat_t r_beat,
    output logic        r_valid,
    input  logic        r_ready
);

    logic in_fire;
    logic rd_fire;
    logic wr_fire;
    logic wr_err; // sticky error over the current write burst

    assign req.ready = (!r_valid || r_ready) && (!b_valid || b_ready);
    assign in_fire   = req.valid && req.ready;
    assign rd_fire   = in_fire && (req.op == OP_READ);
    assign wr_fire   = in_fire && (req.op == OP_WRITE);

    always_ff @(posedge SLAVE_CLK) begin
        if (!SLAVE_RSTN) begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            wr_err  <= 1'b0;
        end else begin
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_fire && req.last) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (wr_fire) begin
                wr_err <= !req.last && (wr_err || req.err);
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (rd_fire) begin
            r_beat <= '{id: req.id, data: req.rdata, resp: req.err ? SLVERR : OKAY,
                        last: req.last};
        end
        if (wr_fire && req.last) begin
            b_beat <= '{id: req.id, resp: (wr_err || req.err) ? SLVERR : OKAY};
        end
    end

    a_r_held: assert property (@(posedge SLAVE_CLK) disable iff (!SLAVE_RSTN)
        r_valid && !r_ready |=> r_valid && $stable(r_beat));
    a_b_held: assert property (@(posedge SLAVE_CLK) disable iff (!SLAVE_RSTN)
        b_valid && !b_ready |=> b_valid && $stable(b_beat));

endmodule

// File: hw/axi_slave_top.sv
`timescale 1ns/1ps

module axi_slave_top import axi_pkg::*, slave_pkg::*; #(
    parameter int FIFO_DEPTH_LOG2 = 2,
    parameter int MEM_WORDS       = MEM_WORDS_DEF
) (
    input  logic              bus_clk,
    input  logic              bus_rstn,
    input  logic              SLAVE_CLK,
    input  logic              SLAVE_RSTN,
    input  logic [ID_W-1:0]   bus_wr_addr_id,
    input  logic [ADDR_W-1:0] bus_wr_addr,
    input  logic [LEN_W-1:0]  bus_wr_addr_len,
    input  logic [1:0]        bus_wr_addr_burst,
    input  logic              bus_wr_addr_valid,
    output logic              bus_wr_addr_ready,
    input  logic [DATA_W-1:0] bus_wr_data,
    input  logic [STRB_W-1:0] bus_wr_strb,
    input  logic              bus_wr_data_last,
    input  logic              bus_wr_data_valid,
    output logic              bus_wr_data_ready,
    output logic [ID_W-1:0]   bus_wr_back_id,
    output logic [1:0]        bus_wr_back_resp,
    output logic              bus_wr_back_valid,
    input  logic              bus_wr_back_ready,
    input  logic [ID_W-1:0]   bus_rd_addr_id,
    input  logic [ADDR_W-1:0] bus_rd_addr,
    input  logic [LEN_W-1:0]  bus_rd_addr_len,
    input  logic [1:0]        bus_rd_addr_burst,
    input  logic              bus_rd_addr_valid,
    output logic              bus_rd_addr_ready,
    output logic [ID_W-1:0]   bus_rd_back_id,
    output logic [DATA_W-1:0] bus_rd_data,
    output logic [1:0]        bus_rd_data_resp,
    output logic              bus_rd_data_last,
    output logic              bus_rd_data_valid,
    input  logic              bus_rd_data_ready
);

    addr_beat_t  aw_beat, ar_beat;
    wdata_beat_t w_beat;
    bresp_beat_t b_beat;
    rdata_beat_t r_beat;
    logic        aw_valid, aw_ready;
    logic        ar_valid, ar_ready;
    logic        w_valid, w_ready;
    logic        b_valid, b_ready;
    logic        r_valid, r_ready;

    slave_req_if req_de ();
    slave_req_if req_ex ();

    // names match across the hierarchy so implicit connections do the wiring
    slave_axi_async #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_axi_async (.*);

    slave_decode #(.MEM_WORDS(MEM_WORDS)) u_decode (.*, .req(req_de));

    slave_execute #(.MEM_WORDS(MEM_WORDS)) u_execute (.*, .req_in(req_de), .req_out(req_ex));

    slave_result u_result (.*, .req(req_ex));

endmodule

// File: tb/tb_axi_slave.sv
`timescale 1ns/1ps

module tb_axi_slave;

    localparam int MEM_WORDS = 256;
    localparam int LIMIT     = 2000; // bus cycles allowed for any single wait

    logic        SLAVE_CLK  = 1'b0;
    logic        SLAVE_RSTN = 1'b0;
    logic        bus_clk    = 1'b0;
    logic        bus_rstn   = 1'b0;
    logic [3:0]  bus_wr_addr_id, bus_rd_addr_id, bus_wr_back_id, bus_rd_back_id;
    logic [31:0] bus_wr_addr, bus_rd_addr, bus_wr_data, bus_rd_data;
    logic [7:0]  bus_wr_addr_len, bus_rd_addr_len;
    logic [1:0]  bus_wr_addr_burst, bus_rd_addr_burst, bus_wr_back_resp, bus_rd_data_resp;
    logic [3:0]  bus_wr_strb;
    logic        bus_wr_addr_valid, bus_wr_addr_ready, bus_rd_addr_valid, bus_rd_addr_ready;
    logic        bus_wr_data_last, bus_wr_data_valid, bus_wr_data_ready;
    logic        bus_wr_back_valid, bus_rd_data_last, bus_rd_data_valid;
    logic        bus_wr_back_ready = 1'b0;
    logic        bus_rd_data_ready = 1'b0;

    logic [31:0] ref_mem [MEM_WORDS];
    logic [15:0] lfsr = 16'd81;
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;
    bit          hung = 1'b0; // set once a wait runs out and ends the stimulus loop

    axi_slave_top #(.FIFO_DEPTH_LOG2(2), .MEM_WORDS(MEM_WORDS)) u_axi_slave_top (.*);

    always #5 SLAVE_CLK = ~SLAVE_CLK;
    always #7 bus_clk = ~bus_clk;

    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    // each ready takes one fresh LFSR bit per bus cycle
    always @(posedge bus_clk) begin
        if (bus_rstn) begin
            bus_rd_data_ready <= rand_bit();
            bus_wr_back_ready <= rand_bit();
        end
    end

    initial begin
        repeat (2) @(posedge SLAVE_CLK);
        SLAVE_RSTN <= 1'b1;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        mismatches++;
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic report_timeout(input string what);
        failures++;
        hung = 1'b1;
        $display("Timeout at time %0t: the %s handshake did not complete within %0d bus cycles",
                 $time, what, LIMIT);
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                               input logic [7:0] len, input logic [1:0] burst,
                               input logic [3:0] strb, input logic [31:0] seed);
        int          waited;
        logic [29:0] idx;
        logic [31:0] word;
        logic        any_err = 1'b0;
        @(posedge bus_clk);
        bus_wr_addr_id    <= id;
        bus_wr_addr       <= addr;
        bus_wr_addr_len   <= len;
        bus_wr_addr_burst <= burst;
        bus_wr_addr_valid <= 1'b1;
        waited = 0;
        @(negedge bus_clk);
        while (!bus_wr_addr_ready && waited < LIMIT) begin
            @(negedge bus_clk);
            waited++;
        end
        if (!bus_wr_addr_ready) begin
            report_timeout("write address");
            return;
        end
        @(posedge bus_clk);
        bus_wr_addr_valid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            idx  = (burst == 2'd0) ? addr[31:2] : addr[31:2] + 30'(beat); // 0 is FIXED
            word = seed + 32'(beat);
            bus_wr_data       <= word;
            bus_wr_strb       <= strb;
            bus_wr_data_last  <= (beat == int'(len));
            bus_wr_data_valid <= 1'b1;
            waited = 0;
            @(negedge bus_clk);
            while (!bus_wr_data_ready && waited < LIMIT) begin
                @(negedge bus_clk);
                waited++;
            end
            if (!bus_wr_data_ready) begin
                report_timeout("write data");
                return;
            end
            @(posedge bus_clk);
            if (idx >= 30'(MEM_WORDS)) begin
                any_err = 1'b1;
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        ref_mem[idx[7:0]][8*b +: 8] = word[8*b +: 8];
                    end
                end
            end
        end
        bus_wr_data_valid <= 1'b0;
        waited = 0;
        @(negedge bus_clk);
        while (!(bus_wr_back_valid && bus_wr_back_ready) && waited < LIMIT) begin
            @(negedge bus_clk);
            waited++;
        end
        if (!(bus_wr_back_valid && bus_wr_back_ready)) begin
            report_timeout("write response");
            return;
        end
        checks++;
        if (bus_wr_back_id !== id) begin
            report_mismatch("bus_wr_back_id", 32'(id), 32'(bus_wr_back_id));
        end
        if (bus_wr_back_resp !== (any_err ? 2'b10 : 2'b00)) begin
            report_mismatch("bus_wr_back_resp", any_err ? 32'd2 : 32'd0, 32'(bus_wr_back_resp));
        end
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                              input logic [7:0] len, input logic [1:0] burst);
        int          waited;
        logic [29:0] idx;
        logic        exp_err;
        logic [31:0] exp_data;
        @(posedge bus_clk);
        bus_rd_addr_id    <= id;
        bus_rd_addr       <= addr;
        bus_rd_addr_len   <= len;
        bus_rd_addr_burst <= burst;
        bus_rd_addr_valid <= 1'b1;
        waited = 0;
        @(negedge bus_clk);
        while (!bus_rd_addr_ready && waited < LIMIT) begin
            @(negedge bus_clk);
            waited++;
        end
        if (!bus_rd_addr_ready) begin
            report_timeout("read address");
            return;
        end
        @(posedge bus_clk);
        bus_rd_addr_valid <= 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            idx      = (burst == 2'd0) ? addr[31:2] : addr[31:2] + 30'(beat);
            exp_err  = (idx >= 30'(MEM_WORDS));
            exp_data = exp_err ? 32'd0 : ref_mem[idx[7:0]];
            waited = 0;
            @(negedge bus_clk);
            while (!(bus_rd_data_valid && bus_rd_data_ready) && waited < LIMIT) begin
                @(negedge bus_clk);
                waited++;
            end
            if (!(bus_rd_data_valid && bus_rd_data_ready)) begin
                report_timeout("read data");
                return;
            end
            checks++;
            if (bus_rd_data !== exp_data) begin
                report_mismatch("bus_rd_data", exp_data, bus_rd_data);
            end
            if (bus_rd_data_resp !== (exp_err ? 2'b10 : 2'b00)) begin
                report_mismatch("bus_rd_data_resp", exp_err ? 32'd2 : 32'd0,
                                32'(bus_rd_data_resp));
            end
            if (bus_rd_back_id !== id) begin
                report_mismatch("bus_rd_back_id", 32'(id), 32'(bus_rd_back_id));
            end
            if (bus_rd_data_last !== (beat == int'(len))) begin
                report_mismatch("bus_rd_data_last", 32'(beat == int'(len)), 32'(bus_rd_data_last));
            end
        end
    endtask

    initial begin
        int          fd;
        int          lines_run;
        string       line;
        logic [7:0]  kind;
        logic [3:0]  id, strb;
        logic [31:0] addr, seed;
        logic [7:0]  len;
        logic [1:0]  burst;
        {bus_wr_addr_id, bus_wr_addr, bus_wr_addr_len, bus_wr_addr_burst} = '0;
        {bus_rd_addr_id, bus_rd_addr, bus_rd_addr_len, bus_rd_addr_burst} = '0;
        {bus_wr_data, bus_wr_strb, bus_wr_data_last} = '0;
        bus_wr_addr_valid = 1'b0;
        bus_rd_addr_valid = 1'b0;
        bus_wr_data_valid = 1'b0;
        lines_run = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        fd = $fopen("tb/axi_stim.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open the stimulus file tb/axi_stim.txt");
        end
        repeat (2) @(posedge bus_clk);
        bus_rstn <= 1'b1;
        while (fd != 0 && !hung && !$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%c %h %h %h %h %h %h", kind, id, addr, len, burst, strb,
                        seed) == 7) begin
                if (kind == "W") begin
                    write_burst(id, addr, len, burst, strb, seed);
                    lines_run++;
                end else if (kind == "R") begin
                    read_burst(id, addr, len, burst);
                    lines_run++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (lines_run == 0) begin
            failures++;
            $display("no transaction was read from the stimulus file");
        end
        repeat (4) @(posedge bus_clk);
        $display("transactions: %0d, checks: %0d, mismatches: %0d, other failures: %0d",
                 lines_run, checks, mismatches, failures);
        if (mismatches == 0 && failures == 0 && !hung) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb/axi_stim.txt
# kind id addr len burst strb seed; W writes, R reads, all other fields in hex
# len is beats minus one, burst 0 FIXED 1 INCR; write beat n carries seed plus n
W 1 00000010 00 1 f 11110000
R 2 00000010 00 1 0 00000000
W 3 00000040 03 1 f a0a0a000
R 4 00000040 03 1 0 00000000
W 5 00000080 03 0 f 5a5a0000
R 6 00000080 00 1 0 00000000
R 7 00000080 03 0 0 00000000
W 8 00000044 00 1 5 ffffffff
R 9 00000040 03 1 0 00000000
W a 00000000 00 1 f 12345678
W b 00000400 01 1 f deadbeef
R c 00000000 00 1 0 00000000
R d 00000400 01 1 0 00000000
W e 000003f8 03 1 f 0badc0de
R f 000003f8 03 1 0 00000000
W 0 00000100 0f 1 f 01020300
R 1 00000100 0f 1 0 00000000

// File: sources.f
hw/axi_pkg.sv
hw/slave_pkg.sv
hw/slave_req_if.sv
hw/async_fifo.sv
hw/slave_axi_async.sv
hw/slave_decode.sv
hw/slave_execute.sv
hw/slave_result.sv
hw/axi_slave_top.sv
tb/tb_axi_slave.sv

// File: run.sh
#!/bin/sh
# build the AXI slave testbench with Verilator, run it, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_axi_slave -f sources.f -o sim_axi_slave \
    && ./obj_dir/sim_axi_slave > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
